//--- project.f
+incdir+src
src/serial_slave_pkg.sv
src/control_decoder.sv
src/write_deserializer.sv
src/ack_retry_unit.sv
src/read_serializer.sv
src/slave_sequencer.sv
src/serial_slave_top.sv
bench/uart_link_model.sv
bench/tb_serial_slave.sv

//--- bench/tb_serial_slave.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module tb_serial_slave;
    import serial_slave_pkg::*;

    localparam int NUM_ROWS    = 12;
    localparam int FRAME_BITS  = 3 + `SLAVE_ID_WIDTH + 1;
    localparam int READ_BITS   = `STATUS_WIDTH + `DATA_WIDTH;
    localparam int CYCLE_LIMIT = NUM_ROWS * (6 + 36 + 4 * 70 + 50);
    localparam slave_id_t DUT_ID = 1;
    localparam logic [1:0] LINK_ACK    = 2'd0;
    localparam logic [1:0] LINK_NAK    = 2'd1;
    localparam logic [1:0] LINK_SILENT = 2'd2;
    localparam logic [1:0] LINK_LATE   = 2'd3;

    // op, start field, id, word, send link mode, status expected on a read
    typedef struct packed {
        logic         write;
        logic [2:0]   start;
        slave_id_t    id;
        data_word_t   data;
        logic [1:0]   link;
        link_status_t status;
    } row_t;

    row_t table_rows [NUM_ROWS];

    logic clk, rstN, control, wd, valid, rd, rvalid, ready;
    logic s_tx_start, s_tx_ready, s_rx_done, g_rx_done, g_tx_start, g_tx_ready;
    data_word_t s_tx_word, g_rx_word, get_word, cur_word;
    link_byte_t s_rx_byte, g_tx_byte;
    logic [1:0] send_mode;
    logic [4:0] get_delay;
    logic link_clear, get_req, rvalid_q;
    logic [READ_BITS-1:0] rd_bits;
    int tx_count, ack_count, rd_count, cycles;

    serial_slave_top #(.SLAVE_ID(DUT_ID)) serial_slave_top_inst (
        .clk(clk), .rstN(rstN), .control(control), .wd(wd), .valid(valid),
        .rd(rd), .rvalid(rvalid), .ready(ready),
        .s_tx_start(s_tx_start), .s_tx_word(s_tx_word), .s_tx_ready(s_tx_ready),
        .s_rx_done(s_rx_done), .s_rx_byte(s_rx_byte),
        .g_rx_done(g_rx_done), .g_rx_word(g_rx_word),
        .g_tx_start(g_tx_start), .g_tx_byte(g_tx_byte), .g_tx_ready(g_tx_ready)
    );

    uart_link_model link_inst (
        .clk(clk), .rstN(rstN), .send_mode(send_mode), .link_clear(link_clear),
        .get_req(get_req), .get_delay(get_delay), .get_word(get_word),
        .s_tx_start(s_tx_start), .s_tx_ready(s_tx_ready), .s_rx_done(s_rx_done),
        .s_rx_byte(s_rx_byte), .g_rx_done(g_rx_done), .g_rx_word(g_rx_word),
        .g_tx_ready(g_tx_ready)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int expected_sends(input logic [1:0] link);
        if (link == LINK_SILENT) begin
            return 1 + `RETRANSMIT_TIMES;
        end
        return (link == LINK_LATE) ? 2 : 1;
    endfunction

    task automatic send_frame(input logic [2:0] start, input slave_id_t id, input logic rw);
        logic [FRAME_BITS-1:0] bits;
        bits = {start, id, rw};
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= bits[i];
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    // first bit lands two cycles after the frame, when the slave is in write
    task automatic write_word(input data_word_t w);
        for (int i = `DATA_WIDTH - 1; i >= 0; i--) begin
            @(posedge clk);
            assert (ready) else report_mismatch("ready low while write bits go in");
            if (i == 15) begin
                // one stalled cycle in the middle of the word
                valid <= 1'b0;
                @(posedge clk);
            end
            valid <= 1'b1;
            wd    <= w[i];
        end
        @(posedge clk);
        valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    // link and read stream monitor
    always @(posedge clk) begin
        if (rstN) begin
            if (s_tx_start) begin
                tx_count++;
                assert (s_tx_word == cur_word) else report_mismatch(
                    $sformatf("s_tx_word %h, expected %h", s_tx_word, cur_word));
            end
            if (g_tx_start) begin
                ack_count++;
                assert (g_tx_ready) else
                    report_mismatch("g_tx_start while the get link was not ready");
                assert (g_tx_byte == `ACK_CODE) else report_mismatch(
                    $sformatf("g_tx_byte %h, expected %h", g_tx_byte, `ACK_CODE));
            end
            if (rvalid) begin
                assert (ack_count == 1 && (rvalid_q || rd_count == 0)) else
                    report_mismatch("rvalid outside one stream after the get-link ack");
                rd_bits = {rd_bits[READ_BITS-2:0], rd};
                rd_count++;
            end
            rvalid_q = rvalid;
        end
    end

    initial begin
        row_t row;
        logic accepted;
        int   exp_tx;
        int   exp_rd;
        void'($urandom(32'hd4ac));
        clk = 1'b0;
        rstN = 1'b0;
        control = 1'b0;
        wd = 1'b0;
        valid = 1'b0;
        send_mode = LINK_ACK;
        link_clear = 1'b0;
        get_req = 1'b0;
        get_delay = 5'd1;
        get_word = '0;
        cur_word = '0;
        rvalid_q = 1'b0;
        cycles = 0;
        table_rows[0]  = '{1'b0, 3'b111, 2'd1, 32'h1234_5678, LINK_ACK, 4'b1010};
        table_rows[1]  = '{1'b1, 3'b111, 2'd1, 32'hDEAD_BEEF, LINK_ACK, 4'b0000};
        table_rows[2]  = '{1'b0, 3'b111, 2'd1, 32'hA5A5_0F0F, LINK_ACK, 4'b1100};
        table_rows[3]  = '{1'b1, 3'b111, 2'd1, 32'h0000_0001, LINK_NAK, 4'b0000};
        table_rows[4]  = '{1'b0, 3'b111, 2'd1, 32'h8000_0000, LINK_ACK, 4'b1010};
        table_rows[5]  = '{1'b1, 3'b111, 2'd1, 32'hCAFE_F00D, LINK_SILENT, 4'b0000};
        table_rows[6]  = '{1'b0, 3'b111, 2'd1, 32'hFFFF_FFFF, LINK_ACK, 4'b1010};
        table_rows[7]  = '{1'b1, 3'b111, 2'd1, 32'h1357_9BDF, LINK_LATE, 4'b0000};
        table_rows[8]  = '{1'b0, 3'b111, 2'd1, 32'h2468_ACE0, LINK_ACK, 4'b1100};
        table_rows[9]  = '{1'b1, 3'b111, 2'd2, 32'h5555_AAAA, LINK_ACK, 4'b0000};
        table_rows[10] = '{1'b0, 3'b101, 2'd1, 32'h0F0F_0F0F, LINK_ACK, 4'b0000};
        table_rows[11] = '{1'b0, 3'b111, 2'd1, 32'h7654_3210, LINK_ACK, 4'b1100};
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        assert (ready && !rvalid && !s_tx_start && !g_tx_start) else
            report_mismatch("outputs not at their reset values");
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = table_rows[r];
            accepted = (row.start == `START_PATTERN) && (row.id == DUT_ID);
            @(posedge clk);
            tx_count = 0;
            ack_count = 0;
            rd_count = 0;
            rd_bits = '0;
            cur_word = row.data;
            send_mode <= row.link;
            link_clear <= 1'b1;
            get_word <= row.data;
            @(posedge clk);
            link_clear <= 1'b0;
            send_frame(row.start, row.id, row.write);
            if (row.write) begin
                write_word(row.data);
            end else if (accepted) begin
                get_req <= 1'b1;
                get_delay <= 5'($urandom % 20 + 1);
                @(posedge clk);
                get_req <= 1'b0;
            end
            if (accepted) begin
                while (ready) @(posedge clk);
                while (!ready) @(posedge clk);
            end else begin
                repeat (40) begin
                    @(posedge clk);
                    assert (ready) else report_mismatch("ready dropped on a rejected frame");
                end
            end
            exp_tx = (accepted && row.write) ? expected_sends(row.link) : 0;
            exp_rd = (accepted && !row.write) ? READ_BITS : 0;
            assert (tx_count == exp_tx) else report_mismatch(
                $sformatf("row %0d: %0d send-link starts, expected %0d", r, tx_count, exp_tx));
            assert (ack_count == (exp_rd != 0)) else report_mismatch(
                $sformatf("row %0d: %0d get-link acks", r, ack_count));
            assert (rd_count == exp_rd) else report_mismatch(
                $sformatf("row %0d: %0d read bits, expected %0d", r, rd_count, exp_rd));
            if (exp_rd != 0) begin
                assert (rd_bits == {row.status, row.data}) else report_mismatch(
                    $sformatf("row %0d: read %h, expected %h", r, rd_bits,
                              {row.status, row.data}));
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- bench/uart_link_model.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module uart_link_model
    import serial_slave_pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [1:0] send_mode,
    input  logic       link_clear,
    input  logic       get_req,
    input  logic [4:0] get_delay,
    input  data_word_t get_word,
    input  logic       s_tx_start,
    output logic       s_tx_ready,
    output logic       s_rx_done,
    output link_byte_t s_rx_byte,
    output logic       g_rx_done,
    output data_word_t g_rx_word,
    output logic       g_tx_ready
);

    // send link modes: 0 ack, 1 nak byte, 2 silent, 3 ack after one timeout
    localparam int REPLY_DELAY = 4;
    // send board busy per word, longer than one acknowledge wait
    localparam int TX_BUSY     = 68;
    // get board turnaround after handing over a word
    localparam int TURN_DELAY  = 3;

    int tx_seen;
    int reply_cnt;
    int get_cnt;
    int tx_busy;
    int turn_cnt;

    assign s_tx_ready = (tx_busy == 0);
    assign g_tx_ready = (turn_cnt == 0);

    initial begin
        s_rx_done = 1'b0;
        s_rx_byte = '0;
        g_rx_done = 1'b0;
        g_rx_word = '0;
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s_rx_done <= 1'b0;
            g_rx_done <= 1'b0;
            tx_seen   <= 0;
            reply_cnt <= 0;
            get_cnt   <= 0;
            tx_busy   <= 0;
            turn_cnt  <= 0;
        end else begin
            s_rx_done <= 1'b0;
            g_rx_done <= 1'b0;
            if (link_clear) begin
                tx_seen <= 0;
            end else if (s_tx_start) begin
                tx_seen <= tx_seen + 1;
            end
            if (s_tx_start) begin
                tx_busy <= TX_BUSY;
            end else if (tx_busy > 0) begin
                tx_busy <= tx_busy - 1;
            end
            // a late board lets the first copy go by
            if (s_tx_start && (send_mode < 2'd2 || (send_mode == 2'd3 && tx_seen >= 1))) begin
                reply_cnt <= REPLY_DELAY;
            end else if (reply_cnt > 0) begin
                reply_cnt <= reply_cnt - 1;
                if (reply_cnt == 1) begin
                    s_rx_done <= 1'b1;
                    s_rx_byte <= (send_mode == 2'd1) ? `NAK_CODE : `ACK_CODE;
                end
            end
            if (turn_cnt > 0) begin
                turn_cnt <= turn_cnt - 1;
            end
            if (get_req) begin
                get_cnt <= get_delay;
            end else if (get_cnt > 0) begin
                get_cnt <= get_cnt - 1;
                if (get_cnt == 1) begin
                    g_rx_done <= 1'b1;
                    g_rx_word <= get_word;
                    turn_cnt  <= TURN_DELAY;
                end
            end
        end
    end

endmodule

//--- src/serial_slave_top.sv
`timescale 1ns/1ps

module serial_slave_top
    import serial_slave_pkg::*;
#(
    parameter slave_id_t SLAVE_ID = 1
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       control,
    input  logic       wd,
    input  logic       valid,
    output logic       rd,
    output logic       rvalid,
    output logic       ready,
    output logic       s_tx_start,
    output data_word_t s_tx_word,
    input  logic       s_tx_ready,
    input  logic       s_rx_done,
    input  link_byte_t s_rx_byte,
    input  logic       g_rx_done,
    input  data_word_t g_rx_word,
    output logic       g_tx_start,
    output link_byte_t g_tx_byte,
    input  logic       g_tx_ready
);

    logic         decode_enable;
    logic         cmd_valid;
    logic         cmd_write;
    logic         wr_enable;
    logic         word_done;
    data_word_t   word;
    logic         fwd_start;
    data_word_t   fwd_word;
    logic         fwd_done;
    logic         fwd_acked;
    logic         rd_start;
    link_status_t rd_status;
    data_word_t   rd_word;
    logic         rd_done;

    control_decoder #(
        .SLAVE_ID (SLAVE_ID)
    ) control_decoder_inst (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .enable    (decode_enable),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write)
    );

    write_deserializer write_deserializer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .wd        (wd),
        .valid     (valid),
        .wr_enable (wr_enable),
        .word      (word),
        .word_done (word_done)
    );

    ack_retry_unit ack_retry_unit_inst (
        .clk        (clk),
        .rstN       (rstN),
        .fwd_start  (fwd_start),
        .fwd_word   (fwd_word),
        .s_tx_ready (s_tx_ready),
        .s_rx_done  (s_rx_done),
        .s_rx_byte  (s_rx_byte),
        .s_tx_start (s_tx_start),
        .s_tx_word  (s_tx_word),
        .fwd_done   (fwd_done),
        .fwd_acked  (fwd_acked)
    );

    read_serializer read_serializer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .rd_start  (rd_start),
        .rd_status (rd_status),
        .rd_word   (rd_word),
        .rd        (rd),
        .rvalid    (rvalid),
        .rd_done   (rd_done)
    );

    slave_sequencer slave_sequencer_inst (
        .clk           (clk),
        .rstN          (rstN),
        .cmd_valid     (cmd_valid),
        .cmd_write     (cmd_write),
        .decode_enable (decode_enable),
        .wr_enable     (wr_enable),
        .word_done     (word_done),
        .word          (word),
        .fwd_start     (fwd_start),
        .fwd_word      (fwd_word),
        .fwd_done      (fwd_done),
        .fwd_acked     (fwd_acked),
        .g_rx_done     (g_rx_done),
        .g_rx_word     (g_rx_word),
        .g_tx_ready    (g_tx_ready),
        .g_tx_start    (g_tx_start),
        .g_tx_byte     (g_tx_byte),
        .rd_start      (rd_start),
        .rd_status     (rd_status),
        .rd_word       (rd_word),
        .rd_done       (rd_done),
        .ready         (ready)
    );

endmodule

//--- src/slave_sequencer.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module slave_sequencer
    import serial_slave_pkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         cmd_valid,
    input  logic         cmd_write,
    output logic         decode_enable,
    output logic         wr_enable,
    input  logic         word_done,
    input  data_word_t   word,
    output logic         fwd_start,
    output data_word_t   fwd_word,
    input  logic         fwd_done,
    input  logic         fwd_acked,
    input  logic         g_rx_done,
    input  data_word_t   g_rx_word,
    input  logic         g_tx_ready,
    output logic         g_tx_start,
    output link_byte_t   g_tx_byte,
    output logic         rd_start,
    output link_status_t rd_status,
    output data_word_t   rd_word,
    input  logic         rd_done,
    output logic         ready
);

    localparam link_byte_t ACK_BYTE = `ACK_CODE;
    localparam link_byte_t NAK_BYTE = `NAK_CODE;

    seq_state_t   state;
    link_status_t status_q;
    // holds the write word on its way out, or the read word on its way back
    data_word_t   data_q;

    assign decode_enable = (state == SEQ_IDLE);
    assign wr_enable     = (state == SEQ_WRITE);
    assign ready         = (state == SEQ_IDLE) || (state == SEQ_WRITE);

    assign fwd_word  = data_q;
    assign rd_word   = data_q;
    assign rd_status = status_q;
    assign g_tx_byte = ACK_BYTE;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= SEQ_IDLE;
            status_q   <= NAK_BYTE[7 -: `STATUS_WIDTH];
            fwd_start  <= 1'b0;
            g_tx_start <= 1'b0;
            rd_start   <= 1'b0;
        end else begin
            fwd_start  <= 1'b0;
            g_tx_start <= 1'b0;
            rd_start   <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cmd_valid) begin
                        state <= cmd_write ? SEQ_WRITE : SEQ_READ_WAIT;
                    end
                end
                SEQ_WRITE: begin
                    if (word_done) begin
                        fwd_start <= 1'b1;
                        state     <= SEQ_FORWARD;
                    end
                end
                SEQ_FORWARD: begin
                    // remembered for the next read
                    if (fwd_done) begin
                        status_q <= fwd_acked ? ACK_BYTE[7 -: `STATUS_WIDTH]
                                              : NAK_BYTE[7 -: `STATUS_WIDTH];
                        state    <= SEQ_IDLE;
                    end
                end
                SEQ_READ_WAIT: begin
                    if (g_rx_done) begin
                        state <= SEQ_SEND_ACK;
                    end
                end
                SEQ_SEND_ACK: begin
                    // ack the previous board and start the master stream together
                    if (g_tx_ready) begin
                        g_tx_start <= 1'b1;
                        rd_start   <= 1'b1;
                        state      <= SEQ_READ_OUT;
                    end
                end
                SEQ_READ_OUT: begin
                    if (rd_done) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_WRITE && word_done) begin
            data_q <= word;
        end else if (state == SEQ_READ_WAIT && g_rx_done) begin
            data_q <= g_rx_word;
        end
    end

endmodule

//--- src/read_serializer.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module read_serializer
    import serial_slave_pkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         rd_start,
    input  link_status_t rd_status,
    input  data_word_t   rd_word,
    output logic         rd,
    output logic         rvalid,
    output logic         rd_done
);

    // status nibble followed by the word
    localparam int SHIFT_LEN = `STATUS_WIDTH + `DATA_WIDTH;
    localparam int CNT_W     = $clog2(SHIFT_LEN);

    logic [SHIFT_LEN-1:0] out_sr;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 shifting;

    assign rd     = out_sr[SHIFT_LEN-1];
    assign rvalid = shifting;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shifting <= 1'b0;
            bit_cnt  <= '0;
            rd_done  <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            if (!shifting) begin
                if (rd_start) begin
                    shifting <= 1'b1;
                    bit_cnt  <= '0;
                end
            end else if (bit_cnt == CNT_W'(SHIFT_LEN - 1)) begin
                shifting <= 1'b0;
                rd_done  <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!shifting && rd_start) begin
            out_sr <= {rd_status, rd_word};
        end else if (shifting) begin
            out_sr <= {out_sr[SHIFT_LEN-2:0], 1'b0};
        end
    end

    // the sequencer only starts a read from its own idle path
    assert property (@(posedge clk) disable iff (!rstN) rd_start |-> !shifting);

endmodule

//--- src/ack_retry_unit.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module ack_retry_unit
    import serial_slave_pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       fwd_start,
    input  data_word_t fwd_word,
    input  logic       s_tx_ready,
    input  logic       s_rx_done,
    input  link_byte_t s_rx_byte,
    output logic       s_tx_start,
    output data_word_t s_tx_word,
    output logic       fwd_done,
    output logic       fwd_acked
);

    localparam int WAIT_W  = $clog2(`ACK_TIMEOUT);
    localparam int RETRY_W = $clog2(`RETRANSMIT_TIMES + 1);

    typedef enum logic [1:0] {
        ARU_IDLE,
        ARU_TX,
        ARU_WAIT
    } aru_state_t;

    aru_state_t         state;
    logic [WAIT_W-1:0]  wait_cnt;
    logic [RETRY_W-1:0] retry_cnt;
    logic               timed_out;

    assign timed_out = (wait_cnt == WAIT_W'(`ACK_TIMEOUT - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= ARU_IDLE;
            wait_cnt   <= '0;
            retry_cnt  <= '0;
            s_tx_start <= 1'b0;
            fwd_done   <= 1'b0;
            fwd_acked  <= 1'b0;
        end else begin
            s_tx_start <= 1'b0;
            fwd_done   <= 1'b0;
            if (state != ARU_IDLE && s_rx_done) begin
                // first byte back ends the transfer, whatever it is
                state     <= ARU_IDLE;
                fwd_done  <= 1'b1;
                fwd_acked <= (s_rx_byte == `ACK_CODE);
            end else begin
                case (state)
                    ARU_IDLE: begin
                        if (fwd_start) begin
                            state     <= ARU_TX;
                            retry_cnt <= '0;
                        end
                    end
                    ARU_TX: begin
                        // hold the pulse until the link can take it
                        if (s_tx_ready) begin
                            s_tx_start <= 1'b1;
                            wait_cnt   <= '0;
                            state      <= ARU_WAIT;
                        end
                    end
                    ARU_WAIT: begin
                        if (!timed_out) begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end else if (retry_cnt == RETRY_W'(`RETRANSMIT_TIMES)) begin
                            // retries used up, report as not acknowledged
                            state     <= ARU_IDLE;
                            fwd_done  <= 1'b1;
                            fwd_acked <= 1'b0;
                        end else begin
                            retry_cnt <= retry_cnt + 1'b1;
                            state     <= ARU_TX;
                        end
                    end
                    default: state <= ARU_IDLE;
                endcase
            end
        end
    end

    // word stays put across retransmissions
    always_ff @(posedge clk) begin
        if (state == ARU_IDLE && fwd_start) begin
            s_tx_word <= fwd_word;
        end
    end

    // the far end must keep ready up until it has seen the start pulse
    assert property (@(posedge clk) disable iff (!rstN) s_tx_start |-> s_tx_ready);

endmodule

//--- src/write_deserializer.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module write_deserializer
    import serial_slave_pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       wd,
    input  logic       valid,
    input  logic       wr_enable,
    output data_word_t word,
    output logic       word_done
);

    localparam int CNT_W = $clog2(`DATA_WIDTH);

    logic [CNT_W-1:0] bit_cnt;
    logic             take;

    assign take = wr_enable && valid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            word_done <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (take) begin
                if (bit_cnt == CNT_W'(`DATA_WIDTH - 1)) begin
                    bit_cnt   <= '0;
                    word_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // msb arrives first
    always_ff @(posedge clk) begin
        if (take) begin
            word <= {word[`DATA_WIDTH-2:0], wd};
        end
    end

endmodule

//--- src/control_decoder.sv
`timescale 1ns/1ps
`include "serial_slave_config.svh"

module control_decoder
    import serial_slave_pkg::*;
#(
    parameter slave_id_t SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic enable,
    output logic cmd_valid,
    output logic cmd_write
);

    // start field, id field, r/w bit
    localparam int FRAME_LEN = 3 + `SLAVE_ID_WIDTH + 1;
    localparam int CNT_W     = $clog2(FRAME_LEN);

    logic [FRAME_LEN-2:0] frame_sr;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 busy;
    logic [FRAME_LEN-1:0] frame;

    // last bit is taken straight from the pin
    assign frame = {frame_sr, control};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
            cmd_write <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (!busy) begin
                // a high bit opens a frame, but not in the cycle a command leaves
                if (enable && !cmd_valid && control) begin
                    busy    <= 1'b1;
                    bit_cnt <= CNT_W'(1);
                end
            end else if (bit_cnt == CNT_W'(FRAME_LEN - 1)) begin
                busy <= 1'b0;
                if (frame[FRAME_LEN-1 -: 3] == `START_PATTERN &&
                    frame[`SLAVE_ID_WIDTH:1] == SLAVE_ID) begin
                    cmd_valid <= 1'b1;
                    cmd_write <= frame[0];
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // frame bits, first bit ends up at the top
    always_ff @(posedge clk) begin
        frame_sr <= {frame_sr[FRAME_LEN-3:0], control};
    end

    // a frame takes six cycles, so commands can never be back to back
    assert property (@(posedge clk) disable iff (!rstN) cmd_valid |=> !cmd_valid);

endmodule

//--- src/serial_slave_pkg.sv
`include "serial_slave_config.svh"

package serial_slave_pkg;

    // one word as carried on the master and uart links
    typedef logic [`DATA_WIDTH-1:0] data_word_t;

    // acknowledge byte on a uart link
    typedef logic [7:0] link_byte_t;

    // slave address as sent in the command frame
    typedef logic [`SLAVE_ID_WIDTH-1:0] slave_id_t;

    // result of the last forwarded write
    typedef logic [`STATUS_WIDTH-1:0] link_status_t;

    // transaction states of the sequencer
    typedef enum logic [2:0] {
        SEQ_IDLE      = 3'd0,
        SEQ_WRITE     = 3'd1,
        SEQ_FORWARD   = 3'd2,
        SEQ_READ_WAIT = 3'd3,
        SEQ_SEND_ACK  = 3'd4,
        SEQ_READ_OUT  = 3'd5
    } seq_state_t;

endpackage

//--- src/serial_slave_config.svh
`ifndef SERIAL_SLAVE_CONFIG_SVH
`define SERIAL_SLAVE_CONFIG_SVH

// word width on the master link and both uart links
`define DATA_WIDTH 32

// id field carried in every command frame
`define SLAVE_ID_WIDTH 2

// leading field of a command frame
`define START_PATTERN 3'b111

// bytes exchanged with the neighbouring boards
`define ACK_CODE 8'hCC
`define NAK_CODE 8'hAA

// acknowledge wait per transmission, and retransmit limit
`define ACK_TIMEOUT 64
`define RETRANSMIT_TIMES 3

// status nibble sent ahead of every read word
`define STATUS_WIDTH 4

`endif
